// ==== program.hex ====
// One instruction per line: op[31:28] ra[27:24] rb[23:20] rc[19:16] imm[15:0]
// Loads src/dst/count, converts, stores status 1, halts
10100000
10200001
10300002
41230000
30400001
20400003
00000000

// ==== all.f ====
+incdir+.
gray_pkg.sv
data_mem.sv
mem_arbiter.sv
ls_core.sv
gray_engine.sv
gray_soc.sv
tb_clock.sv
gray_soc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = gray_soc_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and pass only if the run reports success"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== gray_soc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gray_defines.svh"

module gray_soc_tb;

  localparam int NUM_TESTS      = 5;
  localparam int MAX_PIXELS     = 16;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_PIXELS * 20;

  logic                    clk;
  logic                    reset;
  logic                    run;
  gray_pkg::mem_req_t      host_req;
  logic                    host_grant;
  logic                    host_rvalid;
  logic [`GRAY_DATA_W-1:0] host_rdata;
  logic                    halted;

  int                      errors;
  int                      checks;
  int                      cycles;
  logic [31:0]             rng_state;
  logic [`GRAY_DATA_W-1:0] pixels [MAX_PIXELS];  // Source words of the current block

  tb_clock #(.PERIOD(40)) u_clk (.clk(clk));

  gray_soc u_dut (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .host_req    (host_req),
    .host_grant  (host_grant),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .halted      (halted)
  );

  // Run length guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: no finish after %0d clock cycles, DUT stopped responding", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Luma reference, truncating integer divide
  function automatic logic [`GRAY_DATA_W-1:0] gray_model(input gray_pkg::pixel_t p);
    int sum;
    sum = `GRAY_W_R * int'(p.r) + `GRAY_W_G * int'(p.g) + `GRAY_W_B * int'(p.b);
    return `GRAY_DATA_W'(sum / `GRAY_W_DIV);
  endfunction

  task automatic check_word(input string what, input logic [`GRAY_DATA_W-1:0] got,
                            input logic [`GRAY_DATA_W-1:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("Error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
      else begin
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
      end
  endtask

  task automatic reset_dut();
    @(negedge clk);
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_host_grant(output int waited);
    waited = 0;
    @(posedge clk);
    while (!host_grant) begin
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic host_write(input logic [`GRAY_ADDR_W-1:0] addr,
                            input logic [`GRAY_DATA_W-1:0] data);
    int waited;
    @(negedge clk);
    host_req.valid = 1'b1;
    host_req.write = 1'b1;
    host_req.addr  = addr;
    host_req.wdata = data;
    wait_host_grant(waited);
    @(negedge clk);
    host_req = '0;
  endtask

  task automatic host_read(input logic [`GRAY_ADDR_W-1:0] addr,
                           output logic [`GRAY_DATA_W-1:0] data, output int waited);
    @(negedge clk);
    host_req.valid = 1'b1;
    host_req.write = 1'b0;
    host_req.addr  = addr;
    host_req.wdata = '0;
    wait_host_grant(waited);
    @(negedge clk);
    host_req = '0;
    while (!host_rvalid) @(negedge clk);  // Data tagged for the host
    data = host_rdata;
  endtask

  task automatic write_params(input logic [`GRAY_ADDR_W-1:0] src,
                              input logic [`GRAY_ADDR_W-1:0] dst, input int count);
    host_write(`GRAY_ADDR_W'(`GRAY_PARAM_BASE), `GRAY_DATA_W'(src));
    host_write(`GRAY_ADDR_W'(`GRAY_PARAM_BASE + 1), `GRAY_DATA_W'(dst));
    host_write(`GRAY_ADDR_W'(`GRAY_PARAM_BASE + 2), `GRAY_DATA_W'(count));
    host_write(`GRAY_ADDR_W'(`GRAY_STATUS_ADDR), '0);
  endtask

  task automatic start_run();
    @(negedge clk);
    run = 1'b1;
    @(negedge clk);
    run = 1'b0;
  endtask

  task automatic wait_halted();
    while (!halted) @(negedge clk);
  endtask

  task automatic run_program();
    start_run();
    wait_halted();
  endtask

  task automatic check_status_done();
    logic [`GRAY_DATA_W-1:0] data;
    int                      waited;
    host_read(`GRAY_ADDR_W'(`GRAY_STATUS_ADDR), data, waited);
    check_word("status word", data, 32'd1);
  endtask

  // Memory only, core left idle
  task automatic after_reset_idle();
    logic [`GRAY_ADDR_W-1:0] addr;
    logic [`GRAY_DATA_W-1:0] data;
    int                      waited;
    check_true(!halted, "halted is high right after reset");
    check_true(!host_rvalid, "host_rvalid is high right after reset");
    for (int i = 0; i < 8; i++) begin
      addr = `GRAY_ADDR_W'(240 + i);
      host_write(addr, {8'hC3, addr, ~addr, addr ^ 8'h5A});
    end
    for (int i = 0; i < 8; i++) begin
      addr = `GRAY_ADDR_W'(240 + i);
      host_read(addr, data, waited);
      check_word("host readback", data, {8'hC3, addr, ~addr, addr ^ 8'h5A});
    end
    check_true(!halted, "halted rose without a run pulse");
  endtask

  task automatic convert_primaries();
    logic [`GRAY_DATA_W-1:0] data;
    int                      waited;
    reset_dut();
    host_write(8'd16, 32'h00FF_0000);  // Pure red
    host_write(8'd17, 32'h0000_FF00);
    host_write(8'd18, 32'h0000_00FF);
    for (int i = 0; i < 3; i++) host_write(`GRAY_ADDR_W'(32 + i), 32'hFFFF_FFFF);
    write_params(8'd16, 8'd32, 3);
    run_program();
    host_read(8'd32, data, waited);
    check_word("gray of pure red", data, 32'd76);
    host_read(8'd33, data, waited);
    check_word("gray of pure green", data, 32'd149);
    host_read(8'd34, data, waited);
    check_word("gray of pure blue", data, 32'd29);
    check_status_done();
  endtask

  // Random pixels, optionally with the host hammering the status word
  task automatic convert_block(input logic [`GRAY_ADDR_W-1:0] src,
                               input logic [`GRAY_ADDR_W-1:0] dst, input bit contend);
    logic [`GRAY_DATA_W-1:0] data;
    int                      waited;
    reset_dut();
    for (int i = 0; i < MAX_PIXELS; i++) begin
      rng_state = xorshift32(rng_state);
      pixels[i] = rng_state;
      host_write(`GRAY_ADDR_W'(src + i), pixels[i]);
      host_write(`GRAY_ADDR_W'(dst + i), 32'hFFFF_FFFF);  // Stale marker
    end
    write_params(src, dst, MAX_PIXELS);
    if (contend) begin
      start_run();
      for (int i = 0; i < 32; i++) begin  // Spans the loads and the first pixels
        host_read(`GRAY_ADDR_W'(`GRAY_STATUS_ADDR), data, waited);
        check_word("status during conversion", data, '0);
        check_true(waited == 0, "host waited for grant while the engine was busy");
      end
      check_true(!halted, "program halted before the host reads ended");
      wait_halted();
    end else begin
      run_program();
    end
    for (int i = 0; i < MAX_PIXELS; i++) begin
      host_read(`GRAY_ADDR_W'(dst + i), data, waited);
      check_word("gray word", data, gray_model(gray_pkg::pixel_t'(pixels[i][23:0])));
      host_read(`GRAY_ADDR_W'(src + i), data, waited);
      check_word("source pixel", data, pixels[i]);
    end
    check_status_done();
  endtask

  task automatic convert_empty_job();
    logic [`GRAY_DATA_W-1:0] data;
    int                      waited;
    reset_dut();
    for (int i = 0; i < 4; i++) host_write(`GRAY_ADDR_W'(224 + i), 32'h5A00_0000 | i);
    write_params(8'd64, 8'd224, 0);
    run_program();
    check_status_done();
    for (int i = 0; i < 4; i++) begin
      host_read(`GRAY_ADDR_W'(224 + i), data, waited);
      check_word("untouched destination", data, 32'h5A00_0000 | i);
    end
  endtask

  initial begin
    host_req  = '0;
    run       = 1'b0;
    reset     = 1'b1;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    rng_state = 32'd54058;
    reset_dut();

    after_reset_idle();
    convert_primaries();
    convert_block(8'd64, 8'd128, 1'b0);
    convert_empty_job();
    convert_block(8'd96, 8'd160, 1'b1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free-running testbench clock
module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== gray_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gray_defines.svh"

module gray_soc (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    run,
  input  gray_pkg::mem_req_t      host_req,
  output logic                    host_grant,
  output logic                    host_rvalid,
  output logic [`GRAY_DATA_W-1:0] host_rdata,
  output logic                    halted
);

  gray_pkg::mem_req_t      mem_req, core_req, eng_req;
  logic                    core_grant, eng_grant;
  logic                    core_rvalid, eng_rvalid;
  logic [`GRAY_DATA_W-1:0] mem_rdata;  // Shared by all three peers
  logic                    conv_start, conv_done;
  gray_pkg::conv_cmd_t     conv_cmd;

  assign host_rdata = mem_rdata;

  data_mem u_mem (
    .clk   (clk),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

  mem_arbiter u_arb (
    .clk         (clk),
    .reset       (reset),
    .host_req    (host_req),
    .core_req    (core_req),
    .eng_req     (eng_req),
    .host_grant  (host_grant),
    .core_grant  (core_grant),
    .eng_grant   (eng_grant),
    .mem_req     (mem_req),
    .host_rvalid (host_rvalid),
    .core_rvalid (core_rvalid),
    .eng_rvalid  (eng_rvalid)
  );

  ls_core u_core (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .mem_req    (core_req),
    .grant      (core_grant),
    .rvalid     (core_rvalid),
    .rdata      (mem_rdata),
    .conv_start (conv_start),
    .conv_cmd   (conv_cmd),
    .conv_done  (conv_done),
    .halted     (halted)
  );

  gray_engine u_eng (
    .clk        (clk),
    .reset      (reset),
    .conv_start (conv_start),
    .conv_cmd   (conv_cmd),
    .mem_req    (eng_req),
    .grant      (eng_grant),
    .rvalid     (eng_rvalid),
    .rdata      (mem_rdata),
    .conv_done  (conv_done)
  );

endmodule

`default_nettype wire

// ==== gray_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gray_defines.svh"

// Read pixel, weight and divide, write gray word
module gray_engine (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    conv_start,
  input  gray_pkg::conv_cmd_t     conv_cmd,
  output gray_pkg::mem_req_t      mem_req,
  input  logic                    grant,
  input  logic                    rvalid,
  input  logic [`GRAY_DATA_W-1:0] rdata,
  output logic                    conv_done
);

  // Weights add up to 1000, so ten extra bits hold the sum
  localparam int SUM_W = `GRAY_CHAN_W + 10;

  typedef enum logic [2:0] {S_IDLE, S_RD_REQ, S_RD_WAIT, S_CALC, S_WR_REQ} state_t;

  state_t                  state;
  gray_pkg::conv_cmd_t     cmd_q;
  logic [`GRAY_ADDR_W:0]   idx;
  gray_pkg::pixel_t        pix;
  logic [`GRAY_CHAN_W-1:0] gray;
  logic [SUM_W-1:0]        wsum;
  logic [SUM_W-1:0]        quot;

  assign wsum = SUM_W'(pix.r) * SUM_W'(`GRAY_W_R) +
                SUM_W'(pix.g) * SUM_W'(`GRAY_W_G) +
                SUM_W'(pix.b) * SUM_W'(`GRAY_W_B);
  assign quot = wsum / SUM_W'(`GRAY_W_DIV);  // Truncating divide

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= S_IDLE;
      idx       <= '0;
      conv_done <= 1'b0;
    end else begin
      conv_done <= 1'b0;
      case (state)
        S_IDLE: begin
          idx <= '0;
          if (conv_start) begin
            if (conv_cmd.count == '0) conv_done <= 1'b1;  // Empty job
            else state <= S_RD_REQ;
          end
        end
        S_RD_REQ:  if (grant) state <= S_RD_WAIT;
        S_RD_WAIT: if (rvalid) state <= S_CALC;
        S_CALC:    state <= S_WR_REQ;
        default: begin
          if (grant) begin
            if (idx + 1'b1 == cmd_q.count) begin
              conv_done <= 1'b1;
              state     <= S_IDLE;
            end else begin
              idx   <= idx + 1'b1;
              state <= S_RD_REQ;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && conv_start) cmd_q <= conv_cmd;
    if (state == S_RD_WAIT && rvalid) pix <= rdata[3*`GRAY_CHAN_W-1:0];
    if (state == S_CALC) gray <= quot[`GRAY_CHAN_W-1:0];
  end

  always_comb begin
    mem_req.valid = (state == S_RD_REQ) || (state == S_WR_REQ);
    mem_req.write = (state == S_WR_REQ);
    mem_req.addr  = ((state == S_WR_REQ) ? cmd_q.dst : cmd_q.src) +
                    idx[`GRAY_ADDR_W-1:0];
    mem_req.wdata = {{(`GRAY_DATA_W-`GRAY_CHAN_W){1'b0}}, gray};
  end

  // A new job only arrives once the previous one is finished
  a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
    conv_start |-> state == S_IDLE)
    else $error("conv_start while engine busy");

endmodule

`default_nettype wire

// ==== ls_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gray_defines.svh"

// Multi-cycle load/store core driving the gray engine
module ls_core (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    run,
  output gray_pkg::mem_req_t      mem_req,
  input  logic                    grant,
  input  logic                    rvalid,
  input  logic [`GRAY_DATA_W-1:0] rdata,
  output logic                    conv_start,
  output gray_pkg::conv_cmd_t     conv_cmd,
  input  logic                    conv_done,
  output logic                    halted
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WAIT_CONV, S_HALT
  } state_t;

  state_t                  state;
  logic [`GRAY_PC_W-1:0]   pc;
  logic [`GRAY_DATA_W-1:0] ir;
  logic                    rd_pend;  // LW granted, data not back yet

  logic [`GRAY_DATA_W-1:0] rom [`GRAY_PROG_WORDS];
  logic [`GRAY_DATA_W-1:0] rf [`GRAY_NUM_REGS];

  gray_pkg::opcode_t       op;
  logic [`GRAY_REG_W-1:0]  ra, rb, rc;
  logic [15:0]             imm;
  logic [`GRAY_DATA_W-1:0] op_a, op_b, op_c;
  logic [`GRAY_DATA_W-1:0] sum;
  logic [`GRAY_ADDR_W-1:0] mem_addr;
  logic                    rf_we;
  logic [`GRAY_DATA_W-1:0] rf_wdata;

  initial $readmemh("program.hex", rom);

  // Field split of the instruction word
  assign op  = gray_pkg::opcode_t'(ir[31:28]);
  assign ra  = ir[27 -: `GRAY_REG_W];
  assign rb  = ir[23 -: `GRAY_REG_W];
  assign rc  = ir[19 -: `GRAY_REG_W];
  assign imm = ir[15:0];
  assign sum = op_a + {16'h0000, imm};  // Immediate is zero-extended

  function automatic logic [`GRAY_DATA_W-1:0] rf_read(input logic [`GRAY_REG_W-1:0] idx);
    return (idx == '0) ? '0 : rf[idx];  // r0 is hard zero
  endfunction

  // Write-back from ADDI in EXEC or from returning LW data
  assign rf_we    = (state == S_EXEC && op == gray_pkg::OP_ADDI) ||
                    (state == S_MEM && rd_pend && rvalid);
  assign rf_wdata = (state == S_MEM) ? rdata : sum;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= S_IDLE;
      pc      <= '0;
      rd_pend <= 1'b0;
    end else begin
      case (state)
        S_IDLE:   if (run) state <= S_FETCH;
        S_FETCH: begin
          pc    <= pc + 1'b1;
          state <= S_DECODE;
        end
        S_DECODE: state <= S_EXEC;
        S_EXEC: begin
          case (op)
            gray_pkg::OP_LW,
            gray_pkg::OP_SW:   state <= S_MEM;
            gray_pkg::OP_CONV: state <= S_WAIT_CONV;
            gray_pkg::OP_HALT: state <= S_HALT;
            default:           state <= S_FETCH;  // ADDI done this cycle
          endcase
        end
        S_MEM: begin
          if (rd_pend) begin
            if (rvalid) begin
              rd_pend <= 1'b0;
              state   <= S_FETCH;
            end
          end else if (grant) begin
            if (op == gray_pkg::OP_LW) rd_pend <= 1'b1;
            else state <= S_FETCH;
          end
        end
        S_WAIT_CONV: if (conv_done) state <= S_FETCH;
        default:  state <= S_HALT;  // Stays here until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH) ir <= rom[pc];
    if (state == S_DECODE) begin
      op_a <= rf_read(ra);
      op_b <= rf_read(rb);
      op_c <= rf_read(rc);
    end
    if (state == S_EXEC) mem_addr <= sum[`GRAY_ADDR_W-1:0];
    if (rf_we) rf[rb] <= rf_wdata;
  end

  always_comb begin
    mem_req.valid = (state == S_MEM) && !rd_pend;  // Held until granted
    mem_req.write = (op == gray_pkg::OP_SW);
    mem_req.addr  = mem_addr;
    mem_req.wdata = op_b;
  end

  assign conv_start     = (state == S_EXEC) && (op == gray_pkg::OP_CONV);
  assign conv_cmd.src   = op_a[`GRAY_ADDR_W-1:0];
  assign conv_cmd.dst   = op_b[`GRAY_ADDR_W-1:0];
  assign conv_cmd.count = op_c[`GRAY_ADDR_W:0];
  assign halted         = (state == S_HALT);

  // The engine answers only a core that is waiting for it
  a_done_when_waiting: assert property (@(posedge clk) disable iff (reset)
    conv_done |-> state == S_WAIT_CONV)
    else $error("conv_done while core not in WAIT_CONV");

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

// Fixed priority: host, then core, then engine
module mem_arbiter (
  input  logic               clk,
  input  logic               reset,
  input  gray_pkg::mem_req_t host_req,
  input  gray_pkg::mem_req_t core_req,
  input  gray_pkg::mem_req_t eng_req,
  output logic               host_grant,
  output logic               core_grant,
  output logic               eng_grant,
  output gray_pkg::mem_req_t mem_req,
  output logic               host_rvalid,
  output logic               core_rvalid,
  output logic               eng_rvalid
);

  always_comb begin
    host_grant = host_req.valid;
    core_grant = core_req.valid && !host_req.valid;
    eng_grant  = eng_req.valid && !host_req.valid && !core_req.valid;

    if (host_grant) begin
      mem_req = host_req;
    end else if (core_grant) begin
      mem_req = core_req;
    end else if (eng_grant) begin
      mem_req = eng_req;
    end else begin
      mem_req = '0;  // Idle memory cycle
    end
  end

  // Read owner tracking, so the shared rdata word is tagged for one peer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      host_rvalid <= 1'b0;
      core_rvalid <= 1'b0;
      eng_rvalid  <= 1'b0;
    end else begin
      host_rvalid <= host_grant && !host_req.write;
      core_rvalid <= core_grant && !core_req.write;
      eng_rvalid  <= eng_grant && !eng_req.write;
    end
  end

  // A peer that lost arbitration keeps the same request up
  a_core_holds: assert property (@(posedge clk) disable iff (reset)
    core_req.valid && !core_grant |=> $stable(core_req))
    else $error("core request changed while waiting for grant");

  a_eng_holds: assert property (@(posedge clk) disable iff (reset)
    eng_req.valid && !eng_grant |=> $stable(eng_req))
    else $error("engine request changed while waiting for grant");

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gray_defines.svh"

// Single-port data memory shared by host, core and engine
module data_mem (
  input  logic                    clk,
  input  gray_pkg::mem_req_t      req,
  output logic [`GRAY_DATA_W-1:0] rdata
);

  logic [`GRAY_DATA_W-1:0] mem [`GRAY_MEM_WORDS];

  // Write lands at the granted edge, read word shows up next cycle
  always_ff @(posedge clk) begin
    if (req.valid) begin
      if (req.write) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata <= mem[req.addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== gray_pkg.sv ====
`default_nettype none

`include "gray_defines.svh"

package gray_pkg;

  // One access to the shared data memory
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`GRAY_ADDR_W-1:0] addr;
    logic [`GRAY_DATA_W-1:0] wdata;
  } mem_req_t;

  // Low 24 bits of a pixel word, red on top
  typedef struct packed {
    logic [`GRAY_CHAN_W-1:0] r;
    logic [`GRAY_CHAN_W-1:0] g;
    logic [`GRAY_CHAN_W-1:0] b;
  } pixel_t;

  // Conversion job handed from core to engine
  typedef struct packed {
    logic [`GRAY_ADDR_W-1:0] src;
    logic [`GRAY_ADDR_W-1:0] dst;
    logic [`GRAY_ADDR_W:0]   count;  // Up to a full memory of pixels
  } conv_cmd_t;

  typedef enum logic [3:0] {
    OP_HALT = 4'd0,
    OP_LW   = 4'd1,
    OP_SW   = 4'd2,
    OP_ADDI = 4'd3,
    OP_CONV = 4'd4
  } opcode_t;

endpackage

`default_nettype wire

// ==== gray_defines.svh ====
`ifndef GRAY_DEFINES_SVH
`define GRAY_DEFINES_SVH

// Memory geometry
`define GRAY_DATA_W      32
`define GRAY_ADDR_W      8
`define GRAY_MEM_WORDS   256

// Core program store and register file
`define GRAY_PC_W        5
`define GRAY_PROG_WORDS  32
`define GRAY_REG_W       4
`define GRAY_NUM_REGS    16

// Pixel channel width and luma weights, scaled by 1000
`define GRAY_CHAN_W      8
`define GRAY_W_R         299
`define GRAY_W_G         587
`define GRAY_W_B         114
`define GRAY_W_DIV       1000

// Fixed data memory locations
`define GRAY_PARAM_BASE  0   // src, dst, count follow in order
`define GRAY_STATUS_ADDR 3

`endif
